/* src.f */
tcb_pkg.sv
trace_pkg.sv
tcb_if.sv
trace_fetch.sv
trace_lsu.sv
trace_merge.sv
trace_fifo.sv
trace_serial.sv
degu_trace.sv
degu_trace_tb.sv

/* Bender.yml */
package:
  name: degu_trace

sources:
  - tcb_pkg.sv
  - trace_pkg.sv
  - tcb_if.sv
  - trace_fetch.sv
  - trace_lsu.sv
  - trace_merge.sv
  - trace_fifo.sv
  - trace_serial.sv
  - degu_trace.sv
  - target: test
    files:
      - degu_trace_tb.sv

/* degu_trace_tb.sv */
// testbench that plays a table of instructions on the degu_trace buses and checks the trace words
`timescale 1ns/1ps

module degu_trace_tb;

    localparam logic [1:0] ACC_NONE  = 2'd0;
    localparam logic [1:0] ACC_LOAD  = 2'd1;
    localparam logic [1:0] ACC_STORE = 2'd2;

    // one instruction of the stimulus table
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] ins;
        logic        wen;   // write-back requested
        logic [4:0]  idx;
        logic [31:0] wdt;   // write-back data
        logic [1:0]  kind;  // none, load, store
        logic [31:0] adr;
        logic [1:0]  siz;
        logic [31:0] dat;   // store data or load response
        logic [7:0]  gap;   // idle cycles before next fetch
        logic        drop;  // may be lost in the buffer
    } row_t;

    logic        tcb_ifu;
    logic        rst_n;
    logic        ifu_vld;
    logic        ifu_rdy;
    logic [31:0] ifu_adr;
    logic [31:0] ifu_rdt;
    logic        lsu_vld;
    logic        lsu_rdy;
    logic        lsu_wen;
    logic        lsu_ren;
    logic [31:0] lsu_adr;
    logic [1:0]  lsu_siz;
    logic [31:0] lsu_wdt;
    logic [31:0] lsu_rdt;
    logic        gpr_den;
    logic [4:0]  gpr_did;
    logic [31:0] gpr_ddt;
    logic        trc_vld;
    logic        trc_sof;
    logic [31:0] trc_dat;
    logic        trc_ovf;

    row_t        tab [32];
    int          nrows;
    logic [31:0] exp_w [32][6];   // expected words per row
    int          exp_n [32];
    int          fet_edge [32];   // edge of each fetch transfer
    int          fet_row [256];   // row fetched per cycle or -1 when idle
    int          ncyc;
    int          cyc = 0;         // edges since reset release
    int          limit = 0;       // watchdog length in cycles
    logic [31:0] rng = 32'had4d_93b0;
    logic [31:0] words [6];       // record being collected
    int          wi = 0;
    int          wn = 0;
    int          sof_edge;
    int          row = 0;         // next table row to match
    bit          started = 0;

    initial tcb_ifu = 1'b0;
    always #4 tcb_ifu = ~tcb_ifu;

    always @(posedge tcb_ifu) begin
        if (!rst_n) cyc <= 0;
        else        cyc <= cyc + 1;
    end

    degu_trace degu_trace_i (.*);

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x   = rng;
        x   = x ^ (x << 13);
        x   = x ^ (x >> 17);
        x   = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    ////////////////////
    // stimulus table
    ////////////////////

    task automatic add_row(
        input logic [31:0] pc, input logic [31:0] ins,
        input logic wen, input logic [4:0] idx, input logic [31:0] wdt,
        input logic [1:0] kind, input logic [31:0] adr, input logic [1:0] siz,
        input logic [31:0] dat, input int gap, input logic drop
    );
        tab[nrows] = '{pc, ins, wen, idx, wdt, kind, adr, siz, dat, gap[7:0], drop};
        nrows++;
    endtask

    task automatic build_table();
        nrows = 0;
        add_row(32'h0000_0100, 32'h0000_0013, 0, 0, 0, ACC_NONE, 0, 0, 0, 6, 0);  // plain
        add_row(32'h0000_0104, 32'h0000_4501, 0, 0, 0, ACC_NONE, 0, 0, 0, 6, 0);  // compressed
        add_row(32'h0000_0106, 32'h00a0_0093, 1, 5'd1, xorshift(), ACC_NONE, 0, 0, 0, 6, 0);
        add_row(32'h0000_010a, 32'h0000_0013, 1, 5'd0, xorshift(), ACC_NONE, 0, 0, 0, 6, 0);
        add_row(32'h0000_010e, 32'h00b1_2023, 0, 0, 0,
                ACC_STORE, 32'h2000_0010, 2'd2, xorshift(), 6, 0);
        add_row(32'h0000_0112, 32'h0001_2183, 1, 5'd3, xorshift(),
                ACC_LOAD, 32'h2000_0014, 2'd2, xorshift(), 3, 0);
        add_row(32'h0000_0116, 32'h0001_0203, 1, 5'd4, xorshift(),
                ACC_LOAD, 32'h2000_0019, 2'd0, xorshift(), 1, 0);  // byte load
        add_row(32'h0000_011a, 32'h0051_1023, 0, 0, 0,
                ACC_STORE, 32'h2000_001a, 2'd1, xorshift(), 9, 0);  // half store
        // burst of full records that overflows the buffer
        for (int i = 0; i < 16; i++) begin
            add_row(32'h0000_0200 + 4 * i, xorshift() | 32'h3, 1, 5'(i + 1), xorshift(),
                    (i % 2) ? ACC_LOAD : ACC_STORE, 32'h3000_0000 + 4 * i, 2'd2,
                    xorshift(), (i == 15) ? 40 : 0, 1);
        end
        add_row(32'h0000_0300, 32'h0000_0013, 0, 0, 0, ACC_NONE, 0, 0, 0, 4, 0);
    endtask

    // reference encoder for header layout and word order
    task automatic encode_row(input int r, input logic [15:0] tsp);
        logic        wbu;
        logic        acc;
        logic [31:0] hdr;
        int          n;
        wbu = tab[r].wen && (tab[r].idx != 5'd0);  // x0 leaves no trace
        acc = (tab[r].kind != ACC_NONE);
        hdr = '0;
        hdr[31:16] = tsp;
        hdr[15]    = wbu;
        hdr[14]    = acc;
        hdr[13]    = (tab[r].kind == ACC_STORE);
        hdr[12]    = (tab[r].ins[1:0] == 2'b11);
        hdr[11:10] = acc ? tab[r].siz : 2'd0;
        hdr[4:0]   = wbu ? tab[r].idx : 5'd0;
        exp_w[r][0] = hdr;
        exp_w[r][1] = tab[r].pc;
        exp_w[r][2] = tab[r].ins;
        n = 3;
        if (wbu) begin
            exp_w[r][n] = tab[r].wdt;
            n++;
        end
        if (acc) begin
            exp_w[r][n]     = tab[r].adr;
            exp_w[r][n + 1] = tab[r].dat;  // wdt and rdt use the same field
            n += 2;
        end
        exp_n[r] = n;
    endtask

    ////////////////////
    // bus drive
    ////////////////////

    // cycle c fetches fet_row[c] with response and access one cycle later and write-back two later
    task automatic drive_cycle(input int c);
        int r0;
        int r1;
        int r2;
        r0 = fet_row[c];
        r1 = (c >= 1) ? fet_row[c - 1] : -1;
        r2 = (c >= 2) ? fet_row[c - 2] : -1;
        ifu_vld = 1'b0;
        ifu_adr = '0;
        if (r0 >= 0) begin
            ifu_vld = 1'b1;
            ifu_adr = tab[r0].pc;
            fet_edge[r0] = cyc + 1;      // transfer at the coming edge
            encode_row(r0, 16'(cyc + 2)); // counter value when the record is built
        end
        ifu_rdt = '0;
        lsu_vld = 1'b0;
        lsu_wen = 1'b0;
        lsu_ren = 1'b0;
        lsu_adr = '0;
        lsu_siz = '0;
        lsu_wdt = '0;
        if (r1 >= 0) begin
            ifu_rdt = tab[r1].ins;
            if (tab[r1].kind != ACC_NONE) begin
                lsu_vld = 1'b1;
                lsu_wen = (tab[r1].kind == ACC_STORE);
                lsu_ren = (tab[r1].kind == ACC_LOAD);
                lsu_adr = tab[r1].adr;
                lsu_siz = tab[r1].siz;
                lsu_wdt = lsu_wen ? tab[r1].dat : '0;
            end
        end
        lsu_rdt = '0;
        gpr_den = 1'b0;
        gpr_did = '0;
        gpr_ddt = '0;
        if (r2 >= 0) begin
            if (tab[r2].kind == ACC_LOAD) lsu_rdt = tab[r2].dat;
            gpr_den = tab[r2].wen;
            gpr_did = tab[r2].idx;
            gpr_ddt = tab[r2].wdt;
        end
    endtask

    ////////////////////
    // trace monitor
    ////////////////////

    function automatic bit same_record(input int r);
        int i;
        bit ok;
        ok = (wn == exp_n[r]);
        for (i = 0; i < wn; i++) begin
            if (words[i] !== exp_w[r][i]) ok = 1'b0;
        end
        return ok;
    endfunction

    task automatic match_record();
        int i;
        // burst rows may be dropped while the rest arrive in order
        while (row < nrows && tab[row].drop && !same_record(row)) row++;
        if (row >= nrows) begin
            $display("trace record at %0t ns matches no remaining table row", $time);
            $display("Finished with errors");
            $fatal(1);
        end
        compare("record length", wn, exp_n[row]);
        for (i = 0; i < wn; i++) compare("trc_dat", words[i], exp_w[row][i]);
        if (row == 0) compare("header latency", sof_edge - fet_edge[0], 5);
        row++;
    endtask

    // outputs settle after the rising edge and are sampled on the falling one
    always @(negedge tcb_ifu) begin
        if (rst_n) begin
            if (!started && !trc_sof) compare("trc_ovf", trc_ovf, 1'b0);
            if (trc_sof) begin
                if (wi != 0) compare("trc_sof", 1'b1, 1'b0);  // record cut short
                compare("trc_vld", trc_vld, 1'b1);
                started  = 1'b1;
                words[0] = trc_dat;
                wn       = 3 + trc_dat[15] + 2 * trc_dat[14];  // length from flags
                sof_edge = cyc + 1;
                wi       = 1;
            end else if (wi != 0) begin
                compare("trc_vld", trc_vld, 1'b1);  // no gaps inside a record
                words[wi] = trc_dat;
                wi++;
            end else begin
                compare("trc_vld", trc_vld, 1'b0);
            end
            if (wi != 0 && wi == wn) begin
                match_record();
                wi = 0;
            end
        end
    end

    initial begin
        wait (limit != 0);
        #(limit * 8);
        $display("timeout: trace output did not deliver all records in time");
        $display("Finished with errors");
        $fatal(1);
    end

    initial begin
        rst_n   = 1'b0;
        ifu_vld = 1'b0;
        ifu_rdy = 1'b1;  // memories always ready
        ifu_adr = '0;
        ifu_rdt = '0;
        lsu_vld = 1'b0;
        lsu_rdy = 1'b1;
        lsu_wen = 1'b0;
        lsu_ren = 1'b0;
        lsu_adr = '0;
        lsu_siz = '0;
        lsu_wdt = '0;
        lsu_rdt = '0;
        gpr_den = 1'b0;
        gpr_did = '0;
        gpr_ddt = '0;
        build_table();
        for (int c = 0; c < 256; c++) fet_row[c] = -1;
        ncyc = 0;
        for (int r = 0; r < nrows; r++) begin
            fet_row[ncyc] = r;
            ncyc += 1 + tab[r].gap;
        end
        limit = ncyc + 100;  // gaps and fetches plus drain margin
        repeat (2) @(posedge tcb_ifu);
        #1 rst_n = 1'b1;
        for (int c = 0; c < ncyc + 2; c++) begin
            @(posedge tcb_ifu);
            #1 drive_cycle(c);
        end
        wait (row == nrows);
        repeat (2) @(posedge tcb_ifu);
        compare("trc_ovf", trc_ovf, 1'b1);  // burst overflowed
        $display("Finished with no errors");
        $finish;
    end

endmodule: degu_trace_tb

/* degu_trace.sv */
// trace unit top level, plain core bus and register ports in, trace word stream out
`timescale 1ns/1ps

module degu_trace
    import tcb_pkg::*;
    import trace_pkg::*;
(
    input  logic              tcb_ifu,
    input  logic              rst_n,
    // fetch bus
    input  logic              ifu_vld,
    input  logic              ifu_rdy,
    input  logic [TCB_AW-1:0] ifu_adr,
    input  logic [TCB_DW-1:0] ifu_rdt,
    // load/store bus
    input  logic              lsu_vld,
    input  logic              lsu_rdy,
    input  logic              lsu_wen,
    input  logic              lsu_ren,
    input  logic [TCB_AW-1:0] lsu_adr,
    input  tcb_siz_t          lsu_siz,
    input  logic [TCB_DW-1:0] lsu_wdt,
    input  logic [TCB_DW-1:0] lsu_rdt,
    // register write port
    input  logic              gpr_den,
    input  logic [GPR_IW-1:0] gpr_did,
    input  logic [GPR_DW-1:0] gpr_ddt,
    // trace output
    output logic              trc_vld,
    output logic              trc_sof,
    output logic [TRC_DW-1:0] trc_dat,
    output logic              trc_ovf
);

    tcb_if ifu_bus ();
    tcb_if lsu_bus ();

    // fetch bus is read-only word access
    assign ifu_bus.vld = ifu_vld;
    assign ifu_bus.rdy = ifu_rdy;
    assign ifu_bus.wen = 1'b0;
    assign ifu_bus.ren = 1'b1;
    assign ifu_bus.adr = ifu_adr;
    assign ifu_bus.siz = TCB_SIZ_W;
    assign ifu_bus.wdt = '0;
    assign ifu_bus.rdt = ifu_rdt;

    assign lsu_bus.vld = lsu_vld;
    assign lsu_bus.rdy = lsu_rdy;
    assign lsu_bus.wen = lsu_wen;
    assign lsu_bus.ren = lsu_ren;
    assign lsu_bus.adr = lsu_adr;
    assign lsu_bus.siz = lsu_siz;
    assign lsu_bus.wdt = lsu_wdt;
    assign lsu_bus.rdt = lsu_rdt;

    ////////////////////
    // trace chain
    ////////////////////

    logic     fet_vld;
    fet_rec_t fet_rec;
    logic     mem_vld;
    mem_rec_t mem_rec;
    logic     push;
    ret_rec_t ret_rec;
    logic     pop;
    logic     not_empty;
    ret_rec_t head;

    trace_fetch trace_fetch_i (.tcb_ifu, .rst_n, .bus(ifu_bus), .fet_vld, .fet_rec);

    trace_lsu trace_lsu_i (.tcb_ifu, .rst_n, .bus(lsu_bus), .mem_vld, .mem_rec);

    trace_merge trace_merge_i (
        .tcb_ifu, .rst_n,
        .fet_vld, .fet_rec,
        .mem_vld, .mem_rec,
        .gpr_den, .gpr_did, .gpr_ddt,
        .push, .rec(ret_rec)
    );

    trace_fifo trace_fifo_i (
        .tcb_ifu, .rst_n,
        .push, .wr_rec(ret_rec),
        .pop, .rd_rec(head),
        .not_empty, .ovf(trc_ovf)
    );

    trace_serial trace_serial_i (
        .tcb_ifu, .rst_n,
        .not_empty, .head, .pop,
        .trc_vld, .trc_sof, .trc_dat
    );

endmodule: degu_trace

/* trace_serial.sv */
// trace output serializer, sends each buffered record as three to six words led by sof
`timescale 1ns/1ps

module trace_serial
    import trace_pkg::*;
(
    input  logic              tcb_ifu,
    input  logic              rst_n,
    input  logic              not_empty,
    input  ret_rec_t          head,
    output logic              pop,
    output logic              trc_vld,
    output logic              trc_sof,  // header word
    output logic [TRC_DW-1:0] trc_dat
);

    ret_rec_t          rec;   // record being sent
    logic              busy;
    logic [2:0]        idx;   // 0 hdr 1 pc 2 ins 3 wbu 4 adr 5 dat
    logic [2:0]        nxt;
    logic              last;  // final word of the record
    logic [TRC_DW-1:0] hdr;

    // next word, absent fields skipped
    always_comb begin
        nxt  = 3'd0;
        last = 1'b0;
        case (idx)
            3'd0: nxt = 3'd1;
            3'd1: nxt = 3'd2;
            3'd2: begin
                if      (rec.wbu_ena) nxt  = 3'd3;
                else if (rec.lsu_ena) nxt  = 3'd4;
                else                  last = 1'b1;
            end
            3'd3: begin
                if (rec.lsu_ena) nxt  = 3'd4;
                else             last = 1'b1;
            end
            3'd4: nxt = 3'd5;
            default: last = 1'b1;
        endcase
    end

    assign pop = not_empty && (!busy || last);  // refill on the last word

    always_ff @(posedge tcb_ifu) begin
        if (!rst_n) begin
            busy <= 1'b0;
            idx  <= 3'd0;
        end else if (pop) begin
            busy <= 1'b1;
            idx  <= 3'd0;
        end else if (busy) begin
            busy <= !last;
            idx  <= nxt;
        end
    end

    always_ff @(posedge tcb_ifu) begin
        if (pop) rec <= head;
    end

    ////////////////////
    // word assembly
    ////////////////////

    always_comb begin
        hdr = '0;
        hdr[HDR_TSP +: TRC_TSW] = rec.tsp;
        hdr[HDR_WBU]            = rec.wbu_ena;
        hdr[HDR_LSU]            = rec.lsu_ena;
        hdr[HDR_STO]            = rec.mem.sto;
        hdr[HDR_ISZ]            = rec.fet.siz;
        hdr[HDR_SIZ +: 2]       = rec.mem.siz;
        hdr[HDR_IDX +: GPR_IW]  = rec.wbu_idx;
    end

    always_comb begin
        case (idx)
            3'd0:    trc_dat = hdr;
            3'd1:    trc_dat = rec.fet.pc;
            3'd2:    trc_dat = rec.fet.ins;
            3'd3:    trc_dat = rec.wbu_dat;
            3'd4:    trc_dat = rec.mem.adr;
            default: trc_dat = rec.mem.dat;
        endcase
    end

    assign trc_vld = busy;
    assign trc_sof = busy && (idx == 3'd0);

    // every record has at least PC and instruction behind its header
    assert property (@(posedge tcb_ifu) disable iff (!rst_n)
        trc_sof |=> trc_vld && !trc_sof);

endmodule: trace_serial

/* trace_fifo.sv */
// record buffer between merge and serializer, drops on full and flags it with sticky ovf
`timescale 1ns/1ps

module trace_fifo
    import trace_pkg::*;
(
    input  logic     tcb_ifu,
    input  logic     rst_n,
    input  logic     push,
    input  ret_rec_t wr_rec,
    input  logic     pop,
    output ret_rec_t rd_rec,
    output logic     not_empty,
    output logic     ovf  // set until reset
);

    ret_rec_t           mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   cnt;  // records held
    logic               full;
    logic               wr_ena;
    logic               rd_ena;

    assign full      = (cnt == FIFO_DEPTH[FIFO_AW:0]);
    assign not_empty = (cnt != '0);
    assign wr_ena    = push && !full;  // dropped when full
    assign rd_ena    = pop && not_empty;

    ////////////////////
    // pointers
    ////////////////////

    always_ff @(posedge tcb_ifu) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
            ovf    <= 1'b0;
        end else begin
            if (wr_ena) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            if (rd_ena) rd_ptr <= rd_ptr + 1'b1;
            cnt <= cnt + {{FIFO_AW{1'b0}}, wr_ena} - {{FIFO_AW{1'b0}}, rd_ena};
            if (push && full) ovf <= 1'b1;
        end
    end

    // storage
    always_ff @(posedge tcb_ifu) begin
        if (wr_ena) mem[wr_ptr] <= wr_rec;
    end

    assign rd_rec = mem[rd_ptr];  // head

    // serializer only pops what is there
    assert property (@(posedge tcb_ifu) disable iff (!rst_n) pop |-> not_empty);

endmodule: trace_fifo

/* trace_merge.sv */
// combines fetch, write-back and access parts into one timestamped retirement record
`timescale 1ns/1ps

module trace_merge
    import trace_pkg::*;
(
    input  logic              tcb_ifu,
    input  logic              rst_n,
    // fetch record
    input  logic              fet_vld,
    input  fet_rec_t          fet_rec,
    // access record
    input  logic              mem_vld,
    input  mem_rec_t          mem_rec,
    // register write port
    input  logic              gpr_den,
    input  logic [GPR_IW-1:0] gpr_did,
    input  logic [GPR_DW-1:0] gpr_ddt,
    // to buffer
    output logic              push,
    output ret_rec_t          rec
);

    logic [TRC_TSW-1:0] tsp_cnt;  // cycles since reset release
    logic               wbu_ena;

    assign wbu_ena = gpr_den && (gpr_did != '0);  // x0 writes are discarded

    always_ff @(posedge tcb_ifu) begin
        if (!rst_n) begin
            tsp_cnt <= '0;
            push    <= 1'b0;
        end else begin
            tsp_cnt <= tsp_cnt + 1'b1;  // free running, wraps
            push    <= fet_vld;
        end
    end

    // absent parts are cleared so the header stays clean
    always_ff @(posedge tcb_ifu) begin
        if (fet_vld) begin
            rec.fet     <= fet_rec;
            rec.wbu_ena <= wbu_ena;
            rec.wbu_idx <= wbu_ena ? gpr_did : '0;
            rec.wbu_dat <= wbu_ena ? gpr_ddt : '0;
            rec.lsu_ena <= mem_vld;
            rec.mem     <= mem_vld ? mem_rec : '0;
            rec.tsp     <= tsp_cnt;  // sampled with the fetch strobe
        end
    end

endmodule: trace_merge

/* trace_lsu.sv */
// load/store bus monitor, registers each request and adds the response data to an access record
`timescale 1ns/1ps

module trace_lsu
    import tcb_pkg::*;
    import trace_pkg::*;
(
    input  logic     tcb_ifu,
    input  logic     rst_n,
    tcb_if.mon       bus,
    output logic     mem_vld,  // response cycle of an access
    output mem_rec_t mem_rec
);

    // request captured at the transfer
    logic              acc_wen;
    logic              acc_ren;
    logic [TCB_AW-1:0] acc_adr;
    tcb_siz_t          acc_siz;
    logic [TCB_DW-1:0] acc_wdt;

    always_ff @(posedge tcb_ifu) begin
        if (!rst_n) mem_vld <= 1'b0;
        else        mem_vld <= bus.trn;
    end

    always_ff @(posedge tcb_ifu) begin
        if (bus.trn) begin
            acc_wen <= bus.wen;
            acc_ren <= bus.ren;
            acc_adr <= bus.adr;
            acc_siz <= bus.siz;
            acc_wdt <= bus.wdt;
        end
    end

    // record in the response cycle
    always_comb begin
        mem_rec.sto = acc_wen;
        mem_rec.lod = acc_ren;
        mem_rec.adr = acc_adr;
        mem_rec.siz = acc_siz;
        mem_rec.dat = acc_wen ? acc_wdt : bus.rdt;  // live rdt on loads
    end

    // a transfer is either a load or a store
    assert property (@(posedge tcb_ifu) disable iff (!rst_n)
        bus.trn |-> !(bus.wen && bus.ren));

endmodule: trace_lsu

/* trace_fetch.sv */
// fetch bus monitor, pairs each fetch address with its response into one fetch record
`timescale 1ns/1ps

module trace_fetch
    import tcb_pkg::*;
    import trace_pkg::*;
(
    input  logic     tcb_ifu,
    input  logic     rst_n,
    tcb_if.mon       bus,
    output logic     fet_vld,  // one cycle per fetch
    output fet_rec_t fet_rec
);

    logic              rsp_vld;  // stage 1 is the response cycle
    logic [TCB_AW-1:0] rsp_adr;  // address of the fetch in flight

    // stage strobes
    always_ff @(posedge tcb_ifu) begin
        if (!rst_n) begin
            rsp_vld <= 1'b0;
            fet_vld <= 1'b0;
        end else begin
            rsp_vld <= bus.trn;
            fet_vld <= rsp_vld;
        end
    end

    // payload stages
    always_ff @(posedge tcb_ifu) begin
        if (bus.trn) rsp_adr <= bus.adr;  // hold PC until rdt
        if (rsp_vld) begin
            fet_rec.pc  <= rsp_adr;
            fet_rec.ins <= bus.rdt;
            fet_rec.siz <= &bus.rdt[1:0];  // 2'b11 means 32-bit
        end
    end

    // instruction must be known when it is sampled
    assert property (@(posedge tcb_ifu) disable iff (!rst_n)
        bus.trn |-> ##TCB_DLY !$isunknown(bus.rdt));

endmodule: trace_fetch

/* tcb_if.sv */
// TCB bus bundle, driven from the core side and watched by the trace monitors through mon
`timescale 1ns/1ps

interface tcb_if
    import tcb_pkg::*;
();

    // request
    logic              vld;  // request valid
    logic              wen;  // write enable
    logic              ren;  // read enable
    logic [TCB_AW-1:0] adr;
    tcb_siz_t          siz;
    logic [TCB_DW-1:0] wdt;  // write data

    // response
    logic              rdy;  // accepted by subordinate
    logic [TCB_DW-1:0] rdt;  // read data, TCB_DLY after trn

    logic              trn;  // transfer strobe

    assign trn = vld & rdy;

    // core side
    modport man (
        output vld, wen, ren, adr, siz, wdt,
        input  rdy, rdt, trn
    );

    // passive observer
    modport mon (
        input  vld, wen, ren, adr, siz, wdt,
        input  rdy, rdt, trn
    );

endinterface: tcb_if

/* trace_pkg.sv */
// retirement record types and trace word layout, imported along the whole trace chain
package trace_pkg;

    ////////////////////
    // widths and depth
    ////////////////////

    localparam int unsigned GPR_IW     = 5;   // register index
    localparam int unsigned GPR_DW     = 32;  // register data
    localparam int unsigned TRC_DW     = 32;  // trace output word
    localparam int unsigned TRC_TSW    = 16;  // timestamp in header
    localparam int unsigned FIFO_DEPTH = 4;   // records, power of two
    localparam int unsigned FIFO_AW    = $clog2(FIFO_DEPTH);

    // one fetched instruction
    typedef struct packed {
        logic [tcb_pkg::TCB_AW-1:0] pc;
        logic [tcb_pkg::TCB_DW-1:0] ins;
        logic                       siz;  // 32-bit instruction
    } fet_rec_t;

    // one load or store
    typedef struct packed {
        logic                       sto;
        logic                       lod;
        logic [tcb_pkg::TCB_AW-1:0] adr;
        tcb_pkg::tcb_siz_t          siz;
        logic [tcb_pkg::TCB_DW-1:0] dat;  // wdt on store, rdt on load
    } mem_rec_t;

    // everything known about one retired instruction
    typedef struct packed {
        fet_rec_t           fet;
        logic               wbu_ena;
        logic [GPR_IW-1:0]  wbu_idx;
        logic [GPR_DW-1:0]  wbu_dat;
        logic               lsu_ena;
        mem_rec_t           mem;
        logic [TRC_TSW-1:0] tsp;
    } ret_rec_t;

    ////////////////////
    // header word bits
    ////////////////////

    localparam int unsigned HDR_TSP = 16;  // timestamp lsb
    localparam int unsigned HDR_WBU = 15;
    localparam int unsigned HDR_LSU = 14;
    localparam int unsigned HDR_STO = 13;
    localparam int unsigned HDR_ISZ = 12;
    localparam int unsigned HDR_SIZ = 10;  // access size lsb
    localparam int unsigned HDR_IDX = 0;   // write-back index lsb

endpackage: trace_pkg

/* tcb_pkg.sv */
// TCB system bus geometry and size encoding, imported by every module that touches a TCB bus
package tcb_pkg;

    ////////////////////
    // bus geometry
    ////////////////////

    localparam int unsigned TCB_AW = 32;  // address width
    localparam int unsigned TCB_DW = 32;  // data width

    // read data follows the transfer by this many cycles
    localparam int unsigned TCB_DLY = 1;

    ////////////////////
    // access size
    ////////////////////

    // logarithmic size of an access in bytes
    typedef logic [1:0] tcb_siz_t;

    // full word access, used by the fetch bus
    localparam tcb_siz_t TCB_SIZ_W = 2'd2;

endpackage: tcb_pkg
